//--- rtl/mcu_macros.svh
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// bus widths
`define MCU_AW          14
`define RAM_AW          13
`define MCU_DW          16

// MCU window offsets, low byte of the word offset
`define OFS_DSW         8'h00
`define OFS_CREDITS     8'h22
`define OFS_COIN        8'h29
`define OFS_ID_HI       8'hfe
`define OFS_ID_LO       8'hff

// second write after a shared-id coin lands this many words back
`define COIN_CLR_BACK   7

// coin poll reply bytes
`define COIN_ID_A       8'h23
`define COIN_ID_B       8'h24
`define COIN_ID_SHARED  8'h22

// brd[5:4] code for the rev V board
`define BOARD_REV_V     2'd3

`endif

//--- rtl/mcu_pkg.sv
package mcu_pkg;

  // work RAM word, seen whole or as two byte lanes
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } b;
  } ram_word_u;

  // entry is {coins - 1, credits}, table slot 0 first in the low byte
  function automatic logic [7:0] coin_ratio(input logic rev_v, input logic slot_b,
                                            input logic [7:0] dsw);
    logic [7:0][7:0] tbl;
    logic [2:0]      idx;
    if (rev_v) begin
      idx = ~dsw[3:1];
      tbl = slot_b ? 64'h7131_5111_6121_4101 : 64'h2204_0602_1303_0501;
    end else begin
      idx = ~dsw[2:0];
      tbl = slot_b ? 64'h7161_5141_3121_1101 : 64'h2213_0605_0403_0201;
    end
    return tbl[idx];
  endfunction

  // type 0 has no id
  function automatic logic [7:0] mcu_id_byte(input logic [1:0] mcu_type, input logic hi,
                                             output logic valid);
    logic [15:0] id;
    case (mcu_type)
      2'd1:    id = 16'h8814;
      2'd2:    id = 16'h8512;
      2'd3:    id = 16'h8713;
      default: id = 16'h0000;
    endcase
    valid = (mcu_type != 2'd0);
    return hi ? id[15:8] : id[7:0];
  endfunction

endpackage

//--- rtl/wb_if.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

// Wishbone classic, word addressed into the work RAM
interface wb_if;

  logic [`RAM_AW-1:0] adr;
  logic [`MCU_DW-1:0] dat_w;
  logic [`MCU_DW-1:0] dat_r;
  logic [1:0]         sel;
  logic               we;
  logic               cyc;
  logic               stb;
  logic               ack;

  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

//--- rtl/coin_credit.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module coin_credit (
  input  logic       clk_sys,
  input  logic       reset,
  input  logic       coin_a,
  input  logic       coin_b,
  input  logic [7:0] brd,
  input  logic [7:0] dsw_sp85,
  input  logic       coin_poll,
  input  logic       credit_read,
  output logic [7:0] poll_byte,
  output logic       poll_clear,
  output logic [7:0] credits
);

  logic       coin_latch;
  logic [3:0] coin_count;
  logic       coin_any;
  logic       coin_new;
  logic       coin_type;
  logic       rev_v;
  logic [7:0] ratio;

  assign coin_any  = coin_a | coin_b;
  assign coin_new  = !coin_latch && coin_any;
  assign coin_type = brd[1];
  assign rev_v     = (brd[5:4] == `BOARD_REV_V);

  // slot b wins when both coins are in
  assign ratio = mcu_pkg::coin_ratio(rev_v, coin_b, dsw_sp85);

  // ==================================================
  // poll reply from current state
  // ==================================================
  always_comb begin
    poll_byte  = 8'h00;
    poll_clear = 1'b0;
    if (coin_new) begin
      if (coin_type) begin
        poll_byte = coin_a ? `COIN_ID_A : `COIN_ID_B;
      end else begin
        poll_byte  = `COIN_ID_SHARED;
        poll_clear = 1'b1;
      end
    end
  end

  // ==================================================
  // latch, counter and credits
  // ==================================================
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      coin_latch <= 1'b0;
      coin_count <= 4'd0;
      credits    <= 8'd0;
    end else begin
      if (credit_read) begin
        credits <= 8'd0;
      end
      if (coin_poll) begin
        // released coin re-arms the latch
        coin_latch <= coin_any;
        if (coin_new && !coin_type) begin
          if (coin_count == ratio[7:4]) begin
            coin_count <= 4'd0;
            credits    <= {4'h0, ratio[3:0]};
          end else begin
            coin_count <= coin_count + 4'd1;
          end
        end
      end
    end
  end

endmodule

//--- rtl/mcu_reply.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_reply (
  input  logic [7:0] win_ofs,
  input  logic [7:0] brd,
  input  logic [7:0] dsw_sp85,
  input  logic [7:0] poll_byte,
  input  logic       poll_clear,
  input  logic [7:0] credits,
  output logic [7:0] reply_byte,
  output logic       reply_valid,
  output logic       clear_needed
);

  logic [7:0] id_byte;
  logic       id_valid;

  always_comb begin
    id_byte = mcu_pkg::mcu_id_byte(brd[3:2], win_ofs == `OFS_ID_HI, id_valid);
  end

  // byte written back for each window offset
  always_comb begin
    reply_byte  = 8'h00;
    reply_valid = 1'b0;
    case (win_ofs)
      `OFS_DSW: begin
        reply_byte  = dsw_sp85;
        reply_valid = 1'b1;
      end
      `OFS_CREDITS: begin
        reply_byte  = credits;
        reply_valid = 1'b1;
      end
      `OFS_COIN: begin
        reply_byte  = poll_byte;
        reply_valid = 1'b1;
      end
      `OFS_ID_HI, `OFS_ID_LO: begin
        reply_byte  = id_byte;
        reply_valid = id_valid;
      end
      default: begin
        // no MCU behind this offset
        reply_valid = 1'b0;
      end
    endcase
  end

  // only the coin poll queues the clear seven words back
  assign clear_needed = poll_clear && (win_ofs == `OFS_COIN);

endmodule

//--- rtl/mcu_ctrl.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_ctrl (
  input  logic               clk_sys,
  input  logic               reset,
  input  logic               win_rd,
  input  logic [`RAM_AW-1:0] win_ofs,
  output logic               busy,
  wb_if.master               mcu_wr,
  output logic               coin_poll,
  output logic               credit_read,
  input  logic [7:0]         reply_byte,
  input  logic               reply_valid,
  input  logic               clear_needed
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_PRI  = 2'd1;
  localparam logic [1:0] ST_SEC  = 2'd2;

  logic [1:0]         state;
  logic               sec_q;
  logic [`RAM_AW-1:0] ofs_q;
  logic [`RAM_AW-1:0] clr_adr;
  mcu_pkg::ram_word_u reply_q;

  assign clr_adr = ofs_q - `RAM_AW'(`COIN_CLR_BACK);

  // ==================================================
  // write sequencer
  // ==================================================
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state       <= ST_IDLE;
      sec_q       <= 1'b0;
      coin_poll   <= 1'b0;
      credit_read <= 1'b0;
    end else begin
      coin_poll   <= 1'b0;
      credit_read <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (win_rd) begin
            // reply already captured, state may move now
            coin_poll   <= (win_ofs[7:0] == `OFS_COIN);
            credit_read <= (win_ofs[7:0] == `OFS_CREDITS);
            sec_q       <= clear_needed;
            if (reply_valid) begin
              state <= ST_PRI;
            end else if (clear_needed) begin
              state <= ST_SEC;
            end
          end
        end
        ST_PRI: begin
          if (mcu_wr.ack) begin
            state <= sec_q ? ST_SEC : ST_IDLE;
          end
        end
        default: begin
          if (mcu_wr.ack) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (state == ST_IDLE && win_rd) begin
      ofs_q      <= win_ofs;
      reply_q.b.hi <= reply_byte;
      reply_q.b.lo <= reply_byte;
    end
  end

  // byte on both lanes, low lane selected
  assign mcu_wr.adr   = (state == ST_SEC) ? clr_adr : ofs_q;
  assign mcu_wr.dat_w = (state == ST_SEC) ? '0 : reply_q.word;
  assign mcu_wr.sel   = 2'b01;
  assign mcu_wr.we    = 1'b1;
  assign mcu_wr.cyc   = (state != ST_IDLE);
  assign mcu_wr.stb   = (state != ST_IDLE);

  assign busy = (state != ST_IDLE);

  // arbiter must hold window reads off while a sequence runs
  a_no_rd_when_busy: assert property (
    @(posedge clk_sys) disable iff (reset) win_rd |-> !busy
  );

endmodule

//--- rtl/ram_arbiter.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module ram_arbiter (
  input  logic               clk_sys,
  input  logic               reset,
  input  logic [`MCU_AW-1:0] wb_adr,
  input  logic [`MCU_DW-1:0] wb_dat_w,
  output logic [`MCU_DW-1:0] wb_dat_r,
  input  logic [1:0]         wb_sel,
  input  logic               wb_we,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  output logic               wb_ack,
  wb_if.slave                mcu_wr,
  wb_if.master               ram_bus,
  output logic               win_rd,
  output logic [`RAM_AW-1:0] win_ofs,
  input  logic               busy
);

  localparam logic [1:0] OWN_NONE = 2'd0;
  localparam logic [1:0] OWN_CPU  = 2'd1;
  localparam logic [1:0] OWN_MCU  = 2'd2;

  logic [1:0]         own;
  logic               req_stb;
  logic [`RAM_AW-1:0] req_adr;
  mcu_pkg::ram_word_u req_dat;
  logic [1:0]         req_sel;
  logic               req_we;
  logic               win_ack;
  logic               cpu_req;
  logic               win_req;
  logic               mcu_req;

  assign cpu_req = wb_cyc && wb_stb && !wb_adr[`MCU_AW-1];
  assign win_req = wb_cyc && wb_stb && wb_adr[`MCU_AW-1] && !win_ack;
  assign mcu_req = mcu_wr.cyc && mcu_wr.stb;

  // ==================================================
  // MCU window, answered here with zero
  // ==================================================
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      win_ack <= 1'b0;
      win_rd  <= 1'b0;
      win_ofs <= '0;
    end else begin
      win_ack <= 1'b0;
      win_rd  <= 1'b0;
      // reads wait for the previous write sequence
      if (win_req && (wb_we || !busy)) begin
        win_ack <= 1'b1;
        if (!wb_we) begin
          win_rd  <= 1'b1;
          win_ofs <= wb_adr[`RAM_AW-1:0];
        end
      end
    end
  end

  // ==================================================
  // work RAM arbitration, MCU first
  // ==================================================
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      own     <= OWN_NONE;
      req_stb <= 1'b0;
    end else if (own == OWN_NONE) begin
      if (mcu_req) begin
        own     <= OWN_MCU;
        req_stb <= 1'b1;
      end else if (cpu_req) begin
        own     <= OWN_CPU;
        req_stb <= 1'b1;
      end
    end else if (ram_bus.ack) begin
      own     <= OWN_NONE;
      req_stb <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (own == OWN_NONE) begin
      req_adr      <= mcu_req ? mcu_wr.adr : wb_adr[`RAM_AW-1:0];
      req_dat.word <= mcu_req ? mcu_wr.dat_w : wb_dat_w;
      req_sel      <= mcu_req ? mcu_wr.sel : wb_sel;
      req_we       <= mcu_req ? mcu_wr.we : wb_we;
    end
  end

  assign ram_bus.adr   = req_adr;
  assign ram_bus.dat_w = req_dat.word;
  assign ram_bus.sel   = req_sel;
  assign ram_bus.we    = req_we;
  assign ram_bus.cyc   = req_stb;
  assign ram_bus.stb   = req_stb;

  assign mcu_wr.ack   = (own == OWN_MCU) && ram_bus.ack;
  assign mcu_wr.dat_r = ram_bus.dat_r;

  // window data always reads as zero
  assign wb_ack   = win_ack || ((own == OWN_CPU) && ram_bus.ack);
  assign wb_dat_r = (own == OWN_CPU) ? ram_bus.dat_r : '0;

  a_ack_in_cycle: assert property (
    @(posedge clk_sys) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb)
  );

endmodule

//--- rtl/work_ram.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module work_ram (
  input logic clk_sys,
  wb_if.slave ram_bus
);

  mcu_pkg::ram_word_u mem [0:(1 << `RAM_AW)-1];
  mcu_pkg::ram_word_u wr_d;
  logic               hit;

  assign wr_d.word = ram_bus.dat_w;

  // one access per stb, ack drops stb on the master side
  assign hit = ram_bus.cyc && ram_bus.stb && !ram_bus.ack;

  always_ff @(posedge clk_sys) begin
    if (hit && ram_bus.we) begin
      if (ram_bus.sel[1]) begin
        mem[ram_bus.adr].b.hi <= wr_d.b.hi;
      end
      if (ram_bus.sel[0]) begin
        mem[ram_bus.adr].b.lo <= wr_d.b.lo;
      end
    end
    ram_bus.dat_r <= mem[ram_bus.adr].word;
    ram_bus.ack   <= hit;
  end

  // both CPU and MCU masters must name a lane
  a_write_has_lane: assert property (
    @(posedge clk_sys) (hit && ram_bus.we) |-> (ram_bus.sel != 2'b00)
  );

endmodule

//--- rtl/mcu_top.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_top (
  input  logic               clk_sys,
  input  logic               reset,
  input  logic [`MCU_AW-1:0] wb_adr,
  input  logic [`MCU_DW-1:0] wb_dat_w,
  output logic [`MCU_DW-1:0] wb_dat_r,
  input  logic [1:0]         wb_sel,
  input  logic               wb_we,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  output logic               wb_ack,
  input  logic [7:0]         brd,
  input  logic [7:0]         dsw_sp85,
  input  logic               coin_a,
  input  logic               coin_b
);

  logic               win_rd;
  logic [`RAM_AW-1:0] win_ofs;
  logic               busy;
  logic               coin_poll;
  logic               credit_read;
  logic [7:0]         reply_byte;
  logic               reply_valid;
  logic               clear_needed;
  logic [7:0]         poll_byte;
  logic               poll_clear;
  logic [7:0]         credits;

  wb_if mcu_wr ();
  wb_if ram_bus ();

  ram_arbiter u_arb (
    .clk_sys, .reset,
    .wb_adr, .wb_dat_w, .wb_dat_r, .wb_sel, .wb_we, .wb_cyc, .wb_stb, .wb_ack,
    .mcu_wr (mcu_wr), .ram_bus (ram_bus),
    .win_rd, .win_ofs, .busy
  );

  work_ram u_ram (.clk_sys, .ram_bus (ram_bus));

  mcu_ctrl u_ctrl (
    .clk_sys, .reset, .win_rd, .win_ofs, .busy, .mcu_wr (mcu_wr),
    .coin_poll, .credit_read, .reply_byte, .reply_valid, .clear_needed
  );

  mcu_reply u_reply (
    .win_ofs (win_ofs[7:0]), .brd, .dsw_sp85, .poll_byte, .poll_clear, .credits,
    .reply_byte, .reply_valid, .clear_needed
  );

  coin_credit u_coin (
    .clk_sys, .reset, .coin_a, .coin_b, .brd, .dsw_sp85, .coin_poll, .credit_read,
    .poll_byte, .poll_clear, .credits
  );

endmodule

//--- bench/tb_mcu_top.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module tb_mcu_top;

  localparam string CASE_FILE       = "bench/mcu_cases.txt";
  localparam int    MAX_CASES       = 128;
  localparam int    CYCLES_PER_CASE = 50;
  localparam int    ACK_LIMIT       = 40;
  localparam int    RESET_CYCLES    = 5;
  // coin_poll hits the coin logic two edges after the window ack
  localparam int    POLL_SETTLE     = 2;

  logic               clk_sys;
  logic               reset;
  logic [`MCU_AW-1:0] wb_adr;
  logic [`MCU_DW-1:0] wb_dat_w;
  logic [`MCU_DW-1:0] wb_dat_r;
  logic [1:0]         wb_sel;
  logic               wb_we;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_ack;
  logic [7:0]         brd;
  logic [7:0]         dsw_sp85;
  logic               coin_a;
  logic               coin_b;

  logic [8*24-1:0]    case_name [0:MAX_CASES-1];
  logic [7:0]         case_op   [0:MAX_CASES-1];
  logic [15:0]        case_a    [0:MAX_CASES-1];
  logic [15:0]        case_b    [0:MAX_CASES-1];
  logic [15:0]        case_c    [0:MAX_CASES-1];
  int                 n_cases;
  int                 pass_count;
  int                 fail_count;
  logic               cases_loaded;

  mcu_top uut (
    .clk_sys, .reset,
    .wb_adr, .wb_dat_w, .wb_dat_r, .wb_sel, .wb_we, .wb_cyc, .wb_stb, .wb_ack,
    .brd, .dsw_sp85, .coin_a, .coin_b
  );

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  // ==================================================
  // case file
  // ==================================================
  task automatic load_cases(output logic ok);
    int               fd;
    int               code;
    logic             bad;
    logic [8*24-1:0]  tok;
    logic [8*128-1:0] rest;
    logic [7:0]       op;
    logic [15:0]      a;
    logic [15:0]      b;
    logic [15:0]      c;
    ok  = 1'b0;
    bad = 1'b0;
    fd  = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %0s", CASE_FILE);
    end else begin
      code = $fscanf(fd, "%s", tok);
      while (code == 1 && !bad) begin
        // a lone # starts a comment line
        if (tok[7:0] == 8'h23 && tok[8*24-1:8] == '0) begin
          code = $fgets(rest, fd);
        end else if (n_cases == MAX_CASES) begin
          $display("More than %0d cases in %0s", MAX_CASES, CASE_FILE);
          bad = 1'b1;
        end else begin
          code = $fscanf(fd, "%s %h %h %h", op, a, b, c);
          if (code != 4) begin
            $display("Case %0s has a malformed line", tok);
            bad = 1'b1;
          end else begin
            case_name[n_cases] = tok;
            case_op[n_cases]   = op;
            case_a[n_cases]    = a;
            case_b[n_cases]    = b;
            case_c[n_cases]    = c;
            n_cases++;
          end
        end
        code = $fscanf(fd, "%s", tok);
      end
      $fclose(fd);
      if (n_cases == 0 && !bad) begin
        $display("No cases found in %0s", CASE_FILE);
      end
      ok = !bad && (n_cases > 0);
    end
  endtask

  // ==================================================
  // Wishbone master
  // ==================================================
  task automatic bus_access(input logic [`MCU_AW-1:0] adr, input logic [15:0] dat,
                            input logic [1:0] sel, input logic we,
                            output logic [15:0] rdat, output logic acked);
    int waited;
    @(posedge clk_sys);
    #1;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    wb_we    = we;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    waited   = 0;
    acked    = 1'b0;
    rdat     = '0;
    while (!acked && waited < ACK_LIMIT) begin
      @(posedge clk_sys);
      #1;
      waited++;
      if (wb_ack) begin
        acked = 1'b1;
        rdat  = wb_dat_r;
      end
    end
    // stb held through the ack cycle, dropped in the cycle after
    if (acked) begin
      @(posedge clk_sys);
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic run_case(input int i);
    logic [15:0] rdat;
    logic        acked;
    logic [15:0] expected;
    logic        check_data;
    logic        ok;
    rdat       = '0;
    acked      = 1'b1;
    expected   = '0;
    check_data = 1'b0;
    ok         = 1'b1;
    case (case_op[i])
      "B": begin
        repeat (POLL_SETTLE) @(posedge clk_sys);
        #1;
        brd      = case_a[i][7:0];
        dsw_sp85 = case_b[i][7:0];
      end
      "C": begin
        repeat (POLL_SETTLE) @(posedge clk_sys);
        #1;
        coin_a = case_a[i][0];
        coin_b = case_b[i][0];
      end
      "W": begin
        bus_access({1'b0, case_a[i][12:0]}, case_b[i], case_c[i][1:0], 1'b1, rdat, acked);
      end
      "R": begin
        bus_access({1'b0, case_a[i][12:0]}, 16'h0000, 2'b11, 1'b0, rdat, acked);
        expected   = case_b[i];
        check_data = 1'b1;
      end
      "P": begin
        // window reads always return zero
        bus_access({1'b1, case_a[i][12:0]}, 16'h0000, 2'b11, 1'b0, rdat, acked);
        check_data = 1'b1;
      end
      "X": begin
        bus_access({1'b1, case_a[i][12:0]}, case_b[i], 2'b11, 1'b1, rdat, acked);
      end
      default: begin
        ok = 1'b0;
        $display("%0s: unknown operation %c", case_name[i], case_op[i]);
      end
    endcase
    if (!acked) begin
      ok = 1'b0;
      $display("%0s: no ack from the DUT within %0d cycles", case_name[i], ACK_LIMIT);
    end else if (check_data && rdat !== expected) begin
      ok = 1'b0;
      $display("Mismatch in %0s: expected %h, actual %h", case_name[i], expected, rdat);
    end
    if (ok) begin
      pass_count++;
      $display("ok      %0s", case_name[i]);
    end else begin
      fail_count++;
    end
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================
  initial begin : main
    logic load_ok;
    cases_loaded = 1'b0;
    n_cases      = 0;
    pass_count   = 0;
    fail_count   = 0;
    reset        = 1'b1;
    wb_adr       = '0;
    wb_dat_w     = '0;
    wb_sel       = 2'b00;
    wb_we        = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    brd          = 8'h00;
    dsw_sp85     = 8'h00;
    coin_a       = 1'b0;
    coin_b       = 1'b0;
    load_cases(load_ok);
    if (load_ok) begin
      cases_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_sys);
      #1;
      reset = 1'b0;
      for (int i = 0; i < n_cases; i++) begin
        run_case(i);
      end
    end else begin
      fail_count++;
    end
    $display("%0d cases, %0d passed, %0d failed", n_cases, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cases_loaded);
    repeat (n_cases * CYCLES_PER_CASE) @(posedge clk_sys);
    $display("Timeout after %0d cycles, the case list did not finish",
             n_cases * CYCLES_PER_CASE);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/mcu_pkg.sv
rtl/wb_if.sv
rtl/coin_credit.sv
rtl/mcu_reply.sv
rtl/mcu_ctrl.sv
rtl/ram_arbiter.sv
rtl/work_ram.sv
rtl/mcu_top.sv
bench/tb_mcu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_mcu_top \
  -f project.f

./obj_dir/Vtb_mcu_top | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "run_sim: testbench reported errors, see sim.log"
  exit 1
fi

echo "run_sim: done, see sim.log"

//--- bench/mcu_cases.txt
# columns: name op a b c, numbers in hex
# B brd dsw 0 / C coin_a coin_b 0 / W adr data sel / R adr expect 0 / P ofs 0 0 / X ofs data 0
cfg_type1_rev2      B 06 5a 0
lane_init           W 0100 1234 3
lane_hi             W 0100 ab00 2
lane_lo             W 0100 00cd 1
lane_check          R 0100 abcd 0
dsw_init            W 0000 a5a5 3
dsw_poll            P 0000 0 0
dsw_check           R 0000 a55a 0
# MCU id bytes for each type
id_init_hi          W 00fe 0000 3
id_init_lo          W 00ff 0000 3
id1_hi_poll         P 00fe 0 0
id1_lo_poll         P 00ff 0 0
id1_hi_check        R 00fe 0088 0
id1_lo_check        R 00ff 0014 0
cfg_type2           B 0a 5a 0
id2_hi_poll         P 00fe 0 0
id2_lo_poll         P 00ff 0 0
id2_hi_check        R 00fe 0085 0
id2_lo_check        R 00ff 0012 0
cfg_type3           B 0e 5a 0
id3_hi_poll         P 00fe 0 0
id3_lo_poll         P 00ff 0 0
id3_hi_check        R 00fe 0087 0
id3_lo_check        R 00ff 0013 0
cfg_type0           B 02 5a 0
id0_init            W 00fe 1111 3
id0_hi_poll         P 00fe 0 0
id0_hi_check        R 00fe 1111 0
# coin type 1, one id per slot
coin_init           W 0029 7700 3
coin_a_in           C 1 0 0
coin_a_poll         P 0029 0 0
coin_a_check        R 0029 7723 0
coin_a_held_poll    P 0029 0 0
coin_a_held_check   R 0029 7700 0
coin_a_out          C 0 0 0
coin_a_idle_poll    P 0029 0 0
coin_b_in           C 0 1 0
coin_b_poll         P 0029 0 0
coin_b_check        R 0029 7724 0
coin_b_out          C 0 0 0
coin_b_idle_poll    P 0029 0 0
# coin type 0 on rev II, two coins give three credits
cfg_rev2_shared     B 04 f9 0
cred_init           W 0022 9999 3
r2_c1_in            C 1 0 0
r2_c1_poll          P 0029 0 0
r2_c1_check         R 0029 7722 0
r2_c1_clr_check     R 0022 9900 0
r2_early_init       W 0022 9999 3
r2_early_read       P 0022 0 0
r2_early_check      R 0022 9900 0
r2_c1_out           C 0 0 0
r2_c1_idle_poll     P 0029 0 0
r2_c2_in            C 1 0 0
r2_c2_poll          P 0029 0 0
r2_cred_read        P 0022 0 0
r2_cred_check       R 0022 9903 0
r2_cred_read2       P 0022 0 0
r2_cred_check2      R 0022 9900 0
r2_c2_out           C 0 0 0
r2_c2_idle_poll     P 0029 0 0
# coin type 0 on rev V, slot B table wins with both coins in
cfg_rev5_shared     B 38 06 0
r5_c1_in            C 1 1 0
r5_c1_poll          P 0029 0 0
r5_c1_check         R 0029 7722 0
r5_early_init       W 0022 9955 3
r5_early_read       P 0022 0 0
r5_early_check      R 0022 9900 0
r5_c1_out           C 0 0 0
r5_c1_idle_poll     P 0029 0 0
r5_c2_in            C 0 1 0
r5_c2_poll          P 0029 0 0
r5_cred_read        P 0022 0 0
r5_cred_check       R 0022 9901 0
r5_cred_read2       P 0022 0 0
r5_cred_check2      R 0022 9900 0
r5_c2_out           C 0 0 0
# window writes and offsets with no MCU behind them
win_wr_lanes        X 0100 ffff 0
win_wr_lanes_check  R 0100 abcd 0
win_wr_dsw          X 0000 1234 0
win_wr_dsw_check    R 0000 a55a 0
gap_init            W 0050 beef 3
gap_poll            P 0050 0 0
gap_check           R 0050 beef 0
